// File: Bender.yml
package:
  name: csr_unit

sources:
  - verilog/csr_pkg.sv
  - verilog/csr_exec.sv
  - verilog/csr_counters.sv
  - verilog/csr_trap_regs.sv
  - verilog/csr_unit.sv
  - target: test
    files:
      - bench/csr_unit_tb.sv

// File: bench/csr_unit_tb.sv
// CSR unit testbench
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

  localparam int        ROB_ID_W   = 7;
  localparam int        PREG_W     = 6;
  localparam csr_data_t TVEC_RESET = 32'h0000_0100;
  localparam int        TIMEOUT    = 16;

  // One request with its setup and expected writeback
  typedef struct packed {
    csr_op_e             op;
    csr_addr_t           addr;
    csr_data_t           operand;
    logic [ROB_ID_W-1:0] robid;
    logic [PREG_W-1:0]   rd;
    logic [3:0]          idle;
    logic [3:0]          retires;
    logic                exc;
    csr_epc_t            epc;
    csr_ecause_t         ecause;
    csr_data_t           tval;
    logic                flush;
    logic                drop;
    logic                chk;
    csr_data_t           exp_result;
    logic                exp_error;
    csr_ecause_t         exp_ecause;
    csr_epc_t            exp_tvec;
  } entry_t;

  logic                clk;
  logic                arst_n;
  logic                rename_csr_write;
  csr_req_t            rename_req;
  logic [ROB_ID_W-1:0] rename_robid;
  logic [PREG_W-1:0]   rename_rd;
  logic                rob_flush;
  logic                rob_ret_valid;
  logic                rob_csr_valid;
  csr_epc_t            rob_csr_epc;
  csr_ecause_t         rob_csr_ecause;
  csr_data_t           rob_csr_tval;
  logic                csr_valid;
  logic                csr_error;
  csr_ecause_t         csr_ecause;
  logic [ROB_ID_W-1:0] csr_robid;
  logic [PREG_W-1:0]   csr_rd;
  csr_data_t           csr_result;
  csr_epc_t            csr_tvec;

  // Reference model of the trap registers
  csr_data_t   m_mscratch;
  csr_data_t   m_mtvec;
  csr_data_t   m_mepc;
  csr_data_t   m_mtval;
  csr_ecause_t m_mcause;
  csr_data_t   rng;
  int          cur_idx;
  entry_t      table_q[$];

  always #4 clk = ~clk;

  csr_unit #(
    .ROB_ID_W   (ROB_ID_W),
    .PREG_W     (PREG_W),
    .TVEC_RESET (TVEC_RESET)
  ) dut0 (
    .clk              (clk),
    .arst_n           (arst_n),
    .rename_csr_write (rename_csr_write),
    .rename_req       (rename_req),
    .rename_robid     (rename_robid),
    .rename_rd        (rename_rd),
    .csr_valid        (csr_valid),
    .csr_error        (csr_error),
    .csr_ecause       (csr_ecause),
    .csr_robid        (csr_robid),
    .csr_rd           (csr_rd),
    .csr_result       (csr_result),
    .rob_flush        (rob_flush),
    .rob_ret_valid    (rob_ret_valid),
    .rob_csr_valid    (rob_csr_valid),
    .rob_csr_epc      (rob_csr_epc),
    .rob_csr_ecause   (rob_csr_ecause),
    .rob_csr_tval     (rob_csr_tval),
    .csr_tvec         (csr_tvec)
  );

  function automatic csr_data_t xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      report_failure($sformatf("Fail %s (entry %0d): got 0x%h, expected 0x%h",
                               name, cur_idx, got, exp));
  endtask

  function automatic entry_t new_entry(csr_op_e op, csr_addr_t addr, csr_data_t operand);
    entry_t e;
    e         = '0;
    e.op      = op;
    e.addr    = addr;
    e.operand = operand;
    return e;
  endfunction

  // Fills in expectations from the model, counters are set by the caller
  task automatic add_entry(input entry_t e);
    csr_data_t old_val;
    csr_data_t new_val;
    logic      trap_reg;
    e.robid = ROB_ID_W'(table_q.size() * 3 + 1);
    e.rd    = PREG_W'(table_q.size() + 1);
    if (e.exc) begin
      m_mepc   = {e.epc, 2'b00};
      m_mcause = e.ecause;
      m_mtval  = e.tval;
    end
    e.exp_tvec = m_mtvec[31:2];
    trap_reg   = 1'b1;
    case (e.addr)
      CSR_MSCRATCH: old_val = m_mscratch;
      CSR_MTVEC:    old_val = m_mtvec;
      CSR_MEPC:     old_val = m_mepc;
      CSR_MCAUSE:   old_val = {27'b0, m_mcause};
      CSR_MTVAL:    old_val = m_mtval;
      default: begin
        old_val  = '0;
        trap_reg = 1'b0;
      end
    endcase
    case (e.op)
      CSR_RW:  new_val = e.operand;
      CSR_RS:  new_val = old_val | e.operand;
      CSR_RC:  new_val = old_val & ~e.operand;
      default: new_val = old_val;
    endcase
    if (e.flush || e.addr inside {CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH}) begin
      // Nothing to model
    end else if (!trap_reg) begin
      e.exp_error  = 1'b1;
      e.exp_ecause = ECAUSE_ILLEGAL_INSTR;
      e.exp_result = '0;
      e.chk        = 1'b1;
    end else begin
      e.exp_result = old_val;
      e.chk        = 1'b1;
      if (e.op != CSR_READ) begin
        case (e.addr)
          CSR_MSCRATCH: m_mscratch = new_val;
          CSR_MTVEC:    m_mtvec    = {new_val[31:2], 2'b00};
          CSR_MEPC:     m_mepc     = {new_val[31:2], 2'b00};
          CSR_MCAUSE:   m_mcause   = new_val[4:0];
          default:      m_mtval    = new_val;
        endcase
      end
    end
    table_q.push_back(e);
  endtask

  task automatic build_table();
    entry_t    e;
    csr_data_t v;
    // mscratch read, write, set and clear
    add_entry(new_entry(CSR_RW, CSR_MSCRATCH, xorshift32()));
    add_entry(new_entry(CSR_RS, CSR_MSCRATCH, xorshift32()));
    add_entry(new_entry(CSR_RC, CSR_MSCRATCH, xorshift32()));
    add_entry(new_entry(CSR_READ, CSR_MSCRATCH, xorshift32()));
    add_entry(new_entry(CSR_RW, CSR_MSCRATCH, xorshift32()));
    add_entry(new_entry(CSR_RS, CSR_MSCRATCH, 32'h0));
    // Unknown address, then mscratch unchanged
    add_entry(new_entry(CSR_RW, 12'h7C0, xorshift32()));
    add_entry(new_entry(CSR_READ, CSR_MSCRATCH, '0));
    // minstret carry into the high half
    e = new_entry(CSR_RW, CSR_MINSTRET, 32'hFFFF_FFFF);
    e.chk = 1'b1;
    add_entry(e);
    e = new_entry(CSR_READ, CSR_MINSTRET, '0);
    e.retires    = 4'd3;
    e.chk        = 1'b1;
    e.exp_result = 32'd2;
    add_entry(e);
    e = new_entry(CSR_READ, CSR_MINSTRETH, '0);
    e.chk        = 1'b1;
    e.exp_result = 32'd1;
    add_entry(e);
    // Write lands one edge after accept, read accepted 1 + idle edges later
    v = xorshift32();
    add_entry(new_entry(CSR_RW, CSR_MCYCLE, v));
    e = new_entry(CSR_READ, CSR_MCYCLE, '0);
    e.idle       = 4'd5;
    e.chk        = 1'b1;
    e.exp_result = v + 32'd6;
    add_entry(e);
    // Exception commit and trap registers
    e = new_entry(CSR_READ, CSR_MEPC, '0);
    e.exc    = 1'b1;
    e.epc    = 30'(xorshift32());
    e.ecause = 5'(xorshift32());
    e.tval   = xorshift32();
    add_entry(e);
    add_entry(new_entry(CSR_READ, CSR_MCAUSE, '0));
    add_entry(new_entry(CSR_READ, CSR_MTVAL, '0));
    add_entry(new_entry(CSR_RW, CSR_MTVEC, xorshift32()));
    add_entry(new_entry(CSR_READ, CSR_MTVEC, '0));
    add_entry(new_entry(CSR_RW, CSR_MEPC, xorshift32()));
    add_entry(new_entry(CSR_READ, CSR_MEPC, '0));
    // Flushed request and a strobe during csr_valid
    e = new_entry(CSR_RW, CSR_MSCRATCH, xorshift32());
    e.flush = 1'b1;
    add_entry(e);
    add_entry(new_entry(CSR_READ, CSR_MSCRATCH, '0));
    e = new_entry(CSR_READ, CSR_MSCRATCH, xorshift32());
    e.drop = 1'b1;
    add_entry(e);
    add_entry(new_entry(CSR_READ, CSR_MSCRATCH, '0));
  endtask

  task automatic run_entry(input entry_t e);
    int t;
    repeat (e.idle) @(posedge clk);
    repeat (e.retires) begin
      @(posedge clk);
      rob_ret_valid <= 1'b1;
    end
    if (e.exc) begin
      @(posedge clk);
      rob_ret_valid  <= 1'b0;
      rob_csr_valid  <= 1'b1;
      rob_csr_epc    <= e.epc;
      rob_csr_ecause <= e.ecause;
      rob_csr_tval   <= e.tval;
    end
    @(posedge clk);
    rob_ret_valid    <= 1'b0;
    rob_csr_valid    <= 1'b0;
    rename_csr_write <= 1'b1;
    rename_req       <= '{op: e.op, addr: e.addr, operand: e.operand};
    rename_robid     <= e.robid;
    rename_rd        <= e.rd;
    rob_flush        <= e.flush;
    @(posedge clk);
    rob_flush        <= 1'b0;
    rename_csr_write <= e.drop;
    // Second strobe while the first one is in writeback
    if (e.drop) begin
      rename_req <= '{op: CSR_RW, addr: CSR_MSCRATCH, operand: ~e.operand};
    end
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!csr_valid && t < TIMEOUT);
    if (e.flush) begin
      assert (!csr_valid) else
        report_failure("A request sent with rob_flush produced csr_valid");
    end else begin
      assert (csr_valid) else
        report_failure($sformatf("Timed out waiting for csr_valid on entry %0d", cur_idx));
      check_val("csr_robid", csr_robid, e.robid);
      check_val("csr_rd", csr_rd, e.rd);
      check_val("csr_error", csr_error, e.exp_error);
      check_val("csr_ecause", csr_ecause, e.exp_ecause);
      check_val("csr_tvec", csr_tvec, e.exp_tvec);
      if (e.chk) begin
        check_val("csr_result", csr_result, e.exp_result);
      end
    end
    if (e.drop) begin
      @(posedge clk);
      rename_csr_write <= 1'b0;
      @(negedge clk);
      assert (!csr_valid) else
        report_failure("A strobe given during csr_valid was accepted");
    end
  endtask

  initial begin
    clk              = 1'b0;
    arst_n           = 1'b0;
    rename_csr_write = 1'b0;
    rename_req       = '0;
    rename_robid     = '0;
    rename_rd        = '0;
    rob_flush        = 1'b0;
    rob_ret_valid    = 1'b0;
    rob_csr_valid    = 1'b0;
    rob_csr_epc      = '0;
    rob_csr_ecause   = '0;
    rob_csr_tval     = '0;
    rng              = 32'd55;
    m_mscratch       = '0;
    m_mtvec          = {TVEC_RESET[31:2], 2'b00};
    m_mepc           = '0;
    m_mtval          = '0;
    m_mcause         = '0;
    cur_idx          = -1;
    build_table();
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_val("csr_tvec", csr_tvec, TVEC_RESET[31:2]);
    assert (!csr_valid && !csr_error) else
      report_failure("csr_valid or csr_error high after reset");
    foreach (table_q[i]) begin
      cur_idx = i;
      run_entry(table_q[i]);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: csr_unit.f
verilog/csr_pkg.sv
verilog/csr_exec.sv
verilog/csr_counters.sv
verilog/csr_trap_regs.sv
verilog/csr_unit.sv
bench/csr_unit_tb.sv

// File: verilog/csr_counters.sv
// Machine cycle and retire counters
`timescale 1ns/1ps

module csr_counters import csr_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     rob_ret_valid,
  input  csr_wr_t  csr_wr,
  output csr_cnt_t cnt_rd
);

  logic [63:0] mcycle_q;
  logic [63:0] minstret_q;
  logic        wr_mcycle_lo;
  logic        wr_mcycle_hi;
  logic        wr_minstret_lo;
  logic        wr_minstret_hi;

  assign wr_mcycle_lo   = csr_wr.en && (csr_wr.sel == SEL_MCYCLE);
  assign wr_mcycle_hi   = csr_wr.en && (csr_wr.sel == SEL_MCYCLEH);
  assign wr_minstret_lo = csr_wr.en && (csr_wr.sel == SEL_MINSTRET);
  assign wr_minstret_hi = csr_wr.en && (csr_wr.sel == SEL_MINSTRETH);

  // A half-word write wins over that cycle's increment
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcycle_q <= '0;
    end else if (wr_mcycle_lo) begin
      mcycle_q[31:0] <= csr_wr.data;
    end else if (wr_mcycle_hi) begin
      mcycle_q[63:32] <= csr_wr.data;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
    end
  end

  // Carry into the upper half comes from the full-width add
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      minstret_q <= '0;
    end else if (wr_minstret_lo) begin
      minstret_q[31:0] <= csr_wr.data;
    end else if (wr_minstret_hi) begin
      minstret_q[63:32] <= csr_wr.data;
    end else if (rob_ret_valid) begin
      minstret_q <= minstret_q + 64'd1;
    end
  end

  always_comb begin
    cnt_rd.mcycle   = mcycle_q;
    cnt_rd.minstret = minstret_q;
  end

  // Write data must be fully resolved by the execution stage
  a_wr_data_known: assert property (
    @(posedge clk) disable iff (!arst_n) csr_wr.en |-> !$isunknown(csr_wr.data)
  );

endmodule

// File: verilog/csr_exec.sv
// CSR execution stage
`timescale 1ns/1ps

module csr_exec import csr_pkg::*; #(
  parameter int ROB_ID_W = 7,
  parameter int PREG_W   = 6
) (
  input  logic                clk,
  input  logic                arst_n,
  // Rename side
  input  logic                rename_csr_write,
  input  csr_req_t            rename_req,
  input  logic [ROB_ID_W-1:0] rename_robid,
  input  logic [PREG_W-1:0]   rename_rd,
  input  logic                rob_flush,
  // Register block readbacks
  input  csr_cnt_t            cnt_rd,
  input  csr_trap_t           trap_rd,
  // Writeback
  output logic                csr_valid,
  output logic                csr_error,
  output csr_ecause_t         csr_ecause,
  output logic [ROB_ID_W-1:0] csr_robid,
  output logic [PREG_W-1:0]   csr_rd,
  output csr_data_t           csr_result,
  output csr_wr_t             csr_wr
);

  logic                valid_q;
  logic                accept;
  logic                unknown;
  csr_req_t            req_q;
  logic [ROB_ID_W-1:0] robid_q;
  logic [PREG_W-1:0]   rd_q;
  csr_sel_e            sel;
  csr_data_t           old_val;
  csr_data_t           new_val;

  // One request in flight while rename stalls
  assign accept = rename_csr_write & ~valid_q & ~rob_flush;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q   <= rename_req;
      robid_q <= rename_robid;
      rd_q    <= rename_rd;
    end
  end

  // Address decode
  always_comb begin
    case (req_q.addr)
      CSR_MCYCLE:    sel = SEL_MCYCLE;
      CSR_MCYCLEH:   sel = SEL_MCYCLEH;
      CSR_MINSTRET:  sel = SEL_MINSTRET;
      CSR_MINSTRETH: sel = SEL_MINSTRETH;
      CSR_MSCRATCH:  sel = SEL_MSCRATCH;
      CSR_MTVEC:     sel = SEL_MTVEC;
      CSR_MEPC:      sel = SEL_MEPC;
      CSR_MCAUSE:    sel = SEL_MCAUSE;
      CSR_MTVAL:     sel = SEL_MTVAL;
      default:       sel = SEL_NONE;
    endcase
  end

  // Old value is zero for an unknown address
  always_comb begin
    case (sel)
      SEL_MCYCLE:    old_val = cnt_rd.mcycle[31:0];
      SEL_MCYCLEH:   old_val = cnt_rd.mcycle[63:32];
      SEL_MINSTRET:  old_val = cnt_rd.minstret[31:0];
      SEL_MINSTRETH: old_val = cnt_rd.minstret[63:32];
      SEL_MSCRATCH:  old_val = trap_rd.mscratch;
      SEL_MTVEC:     old_val = trap_rd.mtvec;
      SEL_MEPC:      old_val = trap_rd.mepc;
      SEL_MCAUSE:    old_val = csr_data_t'(trap_rd.mcause);
      SEL_MTVAL:     old_val = trap_rd.mtval;
      default:       old_val = '0;
    endcase
  end

  always_comb begin
    case (req_q.op)
      CSR_RW:  new_val = req_q.operand;
      CSR_RS:  new_val = old_val | req_q.operand;
      CSR_RC:  new_val = old_val & ~req_q.operand;
      default: new_val = old_val;
    endcase
  end

  assign unknown    = (sel == SEL_NONE);
  // A flush in the writeback cycle still kills the request
  assign csr_valid  = valid_q & ~rob_flush;
  assign csr_error  = csr_valid & unknown;
  assign csr_ecause = csr_error ? ECAUSE_ILLEGAL_INSTR : '0;
  assign csr_robid  = robid_q;
  assign csr_rd     = rd_q;
  assign csr_result = old_val;

  always_comb begin
    csr_wr.en   = csr_valid & ~unknown & (req_q.op != CSR_READ);
    csr_wr.sel  = sel;
    csr_wr.data = new_val;
  end

  // Rename relies on a single stall cycle
  a_valid_single: assert property (
    @(posedge clk) disable iff (!arst_n) csr_valid |=> !csr_valid
  );

  // Writes come only from a legal request accepted one edge earlier
  a_wr_legal: assert property (
    @(posedge clk) disable iff (!arst_n)
      csr_wr.en |-> (csr_valid && !csr_error && $past(accept && rename_req.op != CSR_READ))
  );

endmodule

// File: verilog/csr_pkg.sv
// CSR shared types
package csr_pkg;

  // Widths with a meaning of their own
  typedef logic [31:0] csr_data_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  csr_ecause_t;
  typedef logic [29:0] csr_epc_t;

  // Machine trap setup and handling
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MTVAL     = 12'h343;

  // Machine counters, low and high halves
  localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
  localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH = 12'hB82;

  localparam csr_ecause_t ECAUSE_ILLEGAL_INSTR = 5'd2;

  // Low bits of the rename operation code
  typedef enum logic [1:0] {
    CSR_READ = 2'd0,
    CSR_RW   = 2'd1,
    CSR_RS   = 2'd2,
    CSR_RC   = 2'd3
  } csr_op_e;

  // Decoded target register
  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_MCYCLE,
    SEL_MCYCLEH,
    SEL_MINSTRET,
    SEL_MINSTRETH,
    SEL_MSCRATCH,
    SEL_MTVEC,
    SEL_MEPC,
    SEL_MCAUSE,
    SEL_MTVAL
  } csr_sel_e;

  typedef struct packed {
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t operand;
  } csr_req_t;

  // Write port from the execution stage to both register blocks
  typedef struct packed {
    logic      en;
    csr_sel_e  sel;
    csr_data_t data;
  } csr_wr_t;

  typedef struct packed {
    logic [63:0] mcycle;
    logic [63:0] minstret;
  } csr_cnt_t;

  typedef struct packed {
    csr_data_t   mscratch;
    csr_data_t   mtvec;
    csr_data_t   mepc;
    csr_data_t   mtval;
    csr_ecause_t mcause;
  } csr_trap_t;

endpackage

// File: verilog/csr_trap_regs.sv
// Machine trap registers
`timescale 1ns/1ps

module csr_trap_regs import csr_pkg::*; #(
  parameter csr_data_t TVEC_RESET = 32'h0000_0100
) (
  input  logic        clk,
  input  logic        arst_n,
  input  csr_wr_t     csr_wr,
  // Exception commit from the ROB
  input  logic        rob_csr_valid,
  input  csr_epc_t    rob_csr_epc,
  input  csr_ecause_t rob_csr_ecause,
  input  csr_data_t   rob_csr_tval,
  output csr_trap_t   trap_rd,
  output csr_epc_t    csr_tvec
);

  csr_data_t   mscratch_q;
  csr_data_t   mtvec_q;
  csr_data_t   mepc_q;
  csr_data_t   mtval_q;
  csr_ecause_t mcause_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mscratch_q <= '0;
      mtvec_q    <= {TVEC_RESET[31:2], 2'b00};
    end else if (csr_wr.en) begin
      case (csr_wr.sel)
        SEL_MSCRATCH: mscratch_q <= csr_wr.data;
        SEL_MTVEC:    mtvec_q    <= {csr_wr.data[31:2], 2'b00};
        default:      ;
      endcase
    end
  end

  // Exception capture overrides a CSR write in the same cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (rob_csr_valid) begin
      mepc_q   <= {rob_csr_epc, 2'b00};
      mcause_q <= rob_csr_ecause;
      mtval_q  <= rob_csr_tval;
    end else if (csr_wr.en) begin
      case (csr_wr.sel)
        SEL_MEPC:   mepc_q   <= {csr_wr.data[31:2], 2'b00};
        SEL_MCAUSE: mcause_q <= csr_wr.data[4:0];
        SEL_MTVAL:  mtval_q  <= csr_wr.data;
        default:    ;
      endcase
    end
  end

  always_comb begin
    trap_rd.mscratch = mscratch_q;
    trap_rd.mtvec    = mtvec_q;
    trap_rd.mepc     = mepc_q;
    trap_rd.mtval    = mtval_q;
    trap_rd.mcause   = mcause_q;
  end

  // Word-aligned vector for the front end
  assign csr_tvec = mtvec_q[31:2];

  // A committed exception always lands in mcause
  a_cause_capture: assert property (
    @(posedge clk) disable iff (!arst_n)
      rob_csr_valid |=> (mcause_q == $past(rob_csr_ecause))
  );

endmodule

// File: verilog/csr_unit.sv
// CSR unit top level
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; #(
  parameter int        ROB_ID_W   = 7,
  parameter int        PREG_W     = 6,
  parameter csr_data_t TVEC_RESET = 32'h0000_0100
) (
  input  logic                clk,
  input  logic                arst_n,
  // Rename
  input  logic                rename_csr_write,
  input  csr_req_t            rename_req,
  input  logic [ROB_ID_W-1:0] rename_robid,
  input  logic [PREG_W-1:0]   rename_rd,
  // Writeback
  output logic                csr_valid,
  output logic                csr_error,
  output csr_ecause_t         csr_ecause,
  output logic [ROB_ID_W-1:0] csr_robid,
  output logic [PREG_W-1:0]   csr_rd,
  output csr_data_t           csr_result,
  // ROB
  input  logic                rob_flush,
  input  logic                rob_ret_valid,
  input  logic                rob_csr_valid,
  input  csr_epc_t            rob_csr_epc,
  input  csr_ecause_t         rob_csr_ecause,
  input  csr_data_t           rob_csr_tval,
  // Front end
  output csr_epc_t            csr_tvec
);

  csr_wr_t   csr_wr;
  csr_cnt_t  cnt_rd;
  csr_trap_t trap_rd;

  csr_exec #(
    .ROB_ID_W (ROB_ID_W),
    .PREG_W   (PREG_W)
  ) exec0 (
    .clk              (clk),
    .arst_n           (arst_n),
    .rename_csr_write (rename_csr_write),
    .rename_req       (rename_req),
    .rename_robid     (rename_robid),
    .rename_rd        (rename_rd),
    .rob_flush        (rob_flush),
    .cnt_rd           (cnt_rd),
    .trap_rd          (trap_rd),
    .csr_valid        (csr_valid),
    .csr_error        (csr_error),
    .csr_ecause       (csr_ecause),
    .csr_robid        (csr_robid),
    .csr_rd           (csr_rd),
    .csr_result       (csr_result),
    .csr_wr           (csr_wr)
  );

  csr_counters counters0 (
    .clk           (clk),
    .arst_n        (arst_n),
    .rob_ret_valid (rob_ret_valid),
    .csr_wr        (csr_wr),
    .cnt_rd        (cnt_rd)
  );

  csr_trap_regs #(
    .TVEC_RESET (TVEC_RESET)
  ) trap0 (
    .clk            (clk),
    .arst_n         (arst_n),
    .csr_wr         (csr_wr),
    .rob_csr_valid  (rob_csr_valid),
    .rob_csr_epc    (rob_csr_epc),
    .rob_csr_ecause (rob_csr_ecause),
    .rob_csr_tval   (rob_csr_tval),
    .trap_rd        (trap_rd),
    .csr_tvec       (csr_tvec)
  );

endmodule
